//--- hw/soc_pkg.sv
/* bus types shared by the two-master AHB-lite fabric
   single word transfers only, no hsize/hburst/hprot/hmastlock */
package soc_pkg;

   ////////////////////////////////////////////////////////////
   // bus words

   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // only IDLE and NONSEQ are ever issued
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      NONSEQ = 2'b10
   } htrans_e;

   typedef struct packed {
      htrans_e htrans;
      addr_t   haddr;
      logic    hwrite;
      data_t   hwdata;                 // valid one cycle after the address phase
   } ahb_req_t;

   typedef struct packed {
      data_t hrdata;
      logic  hready;
      logic  hresp;                    // 1 = error
   } ahb_rsp_t;

   ////////////////////////////////////////////////////////////
   // slave select, one-hot

   typedef logic [1:0] slv_sel_t;

   localparam int SEL_SRAM = 0;
   localparam int SEL_TMR  = 1;

   // default slave sequence
   typedef enum logic [1:0] {
      ERR_IDLE,
      ERR_FIRST,                       // hready low, hresp high
      ERR_SECOND                       // hready high, hresp high
   } err_state_e;

   ////////////////////////////////////////////////////////////
   // timer register map

   localparam logic [3:0] TMR_CTRL  = 4'h0;
   localparam logic [3:0] TMR_CMP   = 4'h4;
   localparam logic [3:0] TMR_COUNT = 4'h8;   // read only
   localparam logic [3:0] TMR_STAT  = 4'hC;   // bit 0 pending, w1c

   localparam int CTRL_EN = 0;
   localparam int CTRL_IE = 1;

endpackage

//--- hw/timer_counter.sv
/* free-running compare counter, holds while disabled
   a compare value below the count makes it wrap without a match */
`timescale 1ns/1ns

module timer_counter (
   input  logic           hclk_i,
   input  logic           rst_n_i,
   input  logic           enable_i,
   input  soc_pkg::data_t cmp_i,
   output soc_pkg::data_t count_o,
   output logic           match_o
);

   soc_pkg::data_t count_q;

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (enable_i) begin
         if (count_q >= cmp_i) begin
            count_q <= '0;                // wrap the cycle after the match
         end else begin
            count_q <= count_q + 32'd1;
         end
      end
   end

   assign match_o = enable_i && (count_q == cmp_i);
   assign count_o = count_q;

   // after one settled cycle the count stays inside the compare window
   assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      (enable_i && $past(enable_i) && $stable(cmp_i)) |-> (count_q <= cmp_i));

endmodule

//--- hw/timer_regs.sv
/* register block of the single timer, zero wait states
   only the low 4 address bits are decoded, writes to TMR_COUNT are dropped */
`timescale 1ns/1ns

module timer_regs (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  logic              hsel_i,
   input  soc_pkg::ahb_req_t req_i,
   input  logic              hready_i,
   input  logic              match_i,
   input  soc_pkg::data_t    count_i,
   output soc_pkg::data_t    hrdata_o,
   output logic              hreadyout_o,
   output logic              enable_o,
   output soc_pkg::data_t    cmp_o,
   output logic              irq_o
);

   logic           act_q;
   logic           wr_q;
   logic [3:0]     off_q;
   logic [1:0]     ctrl_q;               // {irq enable, count enable}
   soc_pkg::data_t cmp_q;
   logic           pend_q;
   logic           wr_en;

   assign wr_en = act_q && wr_q && hready_i;

   ////////////////////////////////////////////////////////////
   // address phase capture

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         act_q <= 1'b0;
         wr_q  <= 1'b0;
      end else if (hready_i) begin
         act_q <= hsel_i;
         wr_q  <= hsel_i && req_i.hwrite;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (hready_i && hsel_i) begin
         off_q <= req_i.haddr[3:0];
      end
   end

   ////////////////////////////////////////////////////////////
   // registers

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
         cmp_q  <= '0;
         pend_q <= 1'b0;
      end else begin
         if (wr_en && off_q == soc_pkg::TMR_CTRL) begin
            ctrl_q <= req_i.hwdata[1:0];
         end
         if (wr_en && off_q == soc_pkg::TMR_CMP) begin
            cmp_q <= req_i.hwdata;
         end
         // a new match beats a clear in the same cycle
         if (match_i) begin
            pend_q <= 1'b1;
         end else if (wr_en && off_q == soc_pkg::TMR_STAT && req_i.hwdata[0]) begin
            pend_q <= 1'b0;
         end
      end
   end

   // read mux, data phase
   always_comb begin
      case (off_q)
         soc_pkg::TMR_CTRL:  hrdata_o = {30'd0, ctrl_q};
         soc_pkg::TMR_CMP:   hrdata_o = cmp_q;
         soc_pkg::TMR_COUNT: hrdata_o = count_i;
         soc_pkg::TMR_STAT:  hrdata_o = {31'd0, pend_q};
         default:            hrdata_o = '0;
      endcase
   end

   assign hreadyout_o = 1'b1;
   assign enable_o    = ctrl_q[soc_pkg::CTRL_EN];
   assign cmp_o       = cmp_q;
   assign irq_o       = pend_q && ctrl_q[soc_pkg::CTRL_IE];

endmodule

//--- hw/ahb_sram.sv
/* zero-wait word memory, byte lanes ignored
   words never written read back as zero */
`timescale 1ns/1ns

module ahb_sram #(
   parameter int SRAM_DEPTH = 512
) (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  logic              hsel_i,
   input  soc_pkg::ahb_req_t req_i,
   input  logic              hready_i,
   output soc_pkg::data_t    hrdata_o,
   output logic              hreadyout_o
);

   localparam int AW = $clog2(SRAM_DEPTH);

   soc_pkg::data_t  mem [SRAM_DEPTH];
   logic [SRAM_DEPTH-1:0] written_q;     // per word, cleared on reset
   logic            act_q;
   logic            wr_q;
   logic [AW-1:0]   idx_q;
   logic            wr_en;

   assign wr_en = act_q && wr_q && hready_i;

   // address phase
   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         act_q <= 1'b0;
         wr_q  <= 1'b0;
      end else if (hready_i) begin
         act_q <= hsel_i;
         wr_q  <= hsel_i && req_i.hwrite;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (hready_i && hsel_i) begin
         idx_q <= req_i.haddr[AW+1:2];   // word index
      end
   end

   // data phase write
   always_ff @(posedge hclk_i) begin
      if (wr_en) begin
         mem[idx_q] <= req_i.hwdata;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         written_q <= '0;
      end else if (wr_en) begin
         written_q[idx_q] <= 1'b1;
      end
   end

   assign hrdata_o    = written_q[idx_q] ? mem[idx_q] : '0;
   assign hreadyout_o = 1'b1;            // never stalls

endmodule

//--- hw/ahb_decoder.sv
/* base/mask decode for two slave regions plus the default slave
   overlapping regions are illegal, unmapped accesses get a two cycle error
   and read as zero */
`timescale 1ns/1ns

module ahb_decoder #(
   parameter soc_pkg::addr_t SRAM_BASE = 32'h2000_0000,
   parameter soc_pkg::addr_t SRAM_MASK = 32'hE000_0000,
   parameter soc_pkg::addr_t TMR_BASE  = 32'h4000_0400,
   parameter soc_pkg::addr_t TMR_MASK  = 32'hFFFF_FFC0
) (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  soc_pkg::ahb_req_t bus_req_i,
   input  soc_pkg::data_t    sram_rdata_i,
   input  logic              sram_ready_i,
   input  soc_pkg::data_t    tmr_rdata_i,
   input  logic              tmr_ready_i,
   output soc_pkg::slv_sel_t hsel_o,
   output soc_pkg::ahb_rsp_t bus_rsp_o
);

   logic                req_vld;
   logic                miss;
   soc_pkg::slv_sel_t   hit;
   soc_pkg::slv_sel_t   dsel_q;            // data phase select
   soc_pkg::err_state_e err_q;
   soc_pkg::err_state_e err_d;

   ////////////////////////////////////////////////////////////
   // address phase

   assign req_vld = (bus_req_i.htrans == soc_pkg::NONSEQ);

   assign hit[soc_pkg::SEL_SRAM] = ((bus_req_i.haddr & SRAM_MASK) == SRAM_BASE);
   assign hit[soc_pkg::SEL_TMR]  = ((bus_req_i.haddr & TMR_MASK) == TMR_BASE);

   assign hsel_o = req_vld ? hit : '0;
   assign miss   = req_vld && (hit == '0);   // goes to the default slave

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         dsel_q <= '0;
      end else if (bus_rsp_o.hready) begin
         dsel_q <= hsel_o;
      end
   end

   ////////////////////////////////////////////////////////////
   // default slave

   always_comb begin
      err_d = err_q;
      case (err_q)
         soc_pkg::ERR_IDLE: begin
            if (miss && bus_rsp_o.hready) begin
               err_d = soc_pkg::ERR_FIRST;
            end
         end
         soc_pkg::ERR_FIRST:  err_d = soc_pkg::ERR_SECOND;
         // hready is high here, so a new miss starts straight away
         soc_pkg::ERR_SECOND: err_d = miss ? soc_pkg::ERR_FIRST : soc_pkg::ERR_IDLE;
         default:             err_d = soc_pkg::ERR_IDLE;
      endcase
   end

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         err_q <= soc_pkg::ERR_IDLE;
      end else begin
         err_q <= err_d;
      end
   end

   ////////////////////////////////////////////////////////////
   // data phase response mux

   always_comb begin
      bus_rsp_o.hrdata = '0;
      bus_rsp_o.hready = 1'b1;
      bus_rsp_o.hresp  = (err_q != soc_pkg::ERR_IDLE);
      if (err_q == soc_pkg::ERR_FIRST) begin
         bus_rsp_o.hready = 1'b0;
      end else if (dsel_q[soc_pkg::SEL_SRAM]) begin
         bus_rsp_o.hrdata = sram_rdata_i;
         bus_rsp_o.hready = sram_ready_i;
      end else if (dsel_q[soc_pkg::SEL_TMR]) begin
         bus_rsp_o.hrdata = tmr_rdata_i;
         bus_rsp_o.hready = tmr_ready_i;
      end
   end

   // catches overlapping regions set at the top level
   assert property (@(posedge hclk_i) disable iff (!rst_n_i) $onehot0(hsel_o));

endmodule

//--- hw/ahb_arbiter.sv
/* fixed priority with master 0 winning whenever it requests
   a losing master 1 that still owns a data phase gets its response parked
   and handed back once its own address phase is accepted */
`timescale 1ns/1ns

module ahb_arbiter (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  soc_pkg::ahb_req_t m0_req_i,
   input  soc_pkg::ahb_req_t m1_req_i,
   input  soc_pkg::ahb_rsp_t slv_rsp_i,
   output soc_pkg::ahb_rsp_t m0_rsp_o,
   output soc_pkg::ahb_rsp_t m1_rsp_o,
   output soc_pkg::ahb_req_t bus_req_o
);

   logic           m0_act;
   logic           m1_act;
   logic           gnt_m1;
   logic           m1_lose;
   logic           m1_park;
   logic           dp_vld_q;             // a data phase is on the bus
   logic           dp_own_q;             // set when master 1 owns it
   logic           hold_vld_q;
   soc_pkg::data_t hold_rdata_q;
   logic           hold_resp_q;

   assign m0_act  = (m0_req_i.htrans == soc_pkg::NONSEQ);
   assign m1_act  = (m1_req_i.htrans == soc_pkg::NONSEQ);
   assign gnt_m1  = m1_act && !m0_act;
   assign m1_lose = m1_act && m0_act;
   // master 1 data phase finishes while it is being held off
   assign m1_park = m1_lose && dp_vld_q && dp_own_q && slv_rsp_i.hready;

   ////////////////////////////////////////////////////////////
   // request path

   always_comb begin
      bus_req_o        = gnt_m1 ? m1_req_i : m0_req_i;
      bus_req_o.hwdata = dp_own_q ? m1_req_i.hwdata : m0_req_i.hwdata;
   end

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         dp_vld_q <= 1'b0;
         dp_own_q <= 1'b0;
      end else if (slv_rsp_i.hready) begin   // grant only lands on hready
         dp_vld_q <= m0_act || m1_act;
         dp_own_q <= gnt_m1;
      end
   end

   ////////////////////////////////////////////////////////////
   // parked response for master 1

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         hold_vld_q <= 1'b0;
      end else if (m1_park) begin
         hold_vld_q <= 1'b1;
      end else if (gnt_m1 && slv_rsp_i.hready) begin
         hold_vld_q <= 1'b0;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (m1_park) begin
         hold_rdata_q <= slv_rsp_i.hrdata;
         hold_resp_q  <= slv_rsp_i.hresp;
      end
   end

   ////////////////////////////////////////////////////////////
   // response path

   always_comb begin
      m0_rsp_o.hready = slv_rsp_i.hready;
      m0_rsp_o.hrdata = slv_rsp_i.hrdata;
      m0_rsp_o.hresp  = slv_rsp_i.hresp && dp_vld_q && !dp_own_q;

      m1_rsp_o.hready = slv_rsp_i.hready && !m1_lose;   // back-pressure
      m1_rsp_o.hrdata = hold_vld_q ? hold_rdata_q : slv_rsp_i.hrdata;
      m1_rsp_o.hresp  = hold_vld_q ? hold_resp_q
                                   : (slv_rsp_i.hresp && dp_vld_q && dp_own_q);
   end

   // a granted address phase is taken by exactly one master
   assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      ((m0_act || m1_act) && slv_rsp_i.hready)
      |-> ((m0_act && m0_rsp_o.hready) != (m1_act && m1_rsp_o.hready)));

endmodule

//--- hw/ahb_fabric_top.sv
/* two-master AHB-lite fabric with SRAM and timer
   memory map comes from the parameters, regions must not overlap */
`timescale 1ns/1ns

module ahb_fabric_top #(
   parameter soc_pkg::addr_t SRAM_BASE  = 32'h2000_0000,
   parameter soc_pkg::addr_t SRAM_MASK  = 32'hE000_0000,
   parameter soc_pkg::addr_t TMR_BASE   = 32'h4000_0400,
   parameter soc_pkg::addr_t TMR_MASK   = 32'hFFFF_FFC0,
   parameter int             SRAM_DEPTH = 512
) (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  soc_pkg::ahb_req_t m0_req_i,     // processor port, highest priority
   input  soc_pkg::ahb_req_t m1_req_i,     // dma port
   output soc_pkg::ahb_rsp_t m0_rsp_o,
   output soc_pkg::ahb_rsp_t m1_rsp_o,
   output logic              irq_o
);

   soc_pkg::ahb_req_t bus_req;
   soc_pkg::ahb_rsp_t bus_rsp;
   soc_pkg::slv_sel_t hsel;
   soc_pkg::data_t    sram_rdata;
   logic              sram_ready;
   soc_pkg::data_t    tmr_rdata;
   logic              tmr_ready;
   logic              tmr_enable;
   soc_pkg::data_t    tmr_cmp;
   soc_pkg::data_t    tmr_count;
   logic              tmr_match;

   ahb_arbiter arbiter (
      .hclk_i    ( hclk_i   ),
      .rst_n_i   ( rst_n_i  ),
      .m0_req_i  ( m0_req_i ),
      .m1_req_i  ( m1_req_i ),
      .slv_rsp_i ( bus_rsp  ),
      .m0_rsp_o  ( m0_rsp_o ),
      .m1_rsp_o  ( m1_rsp_o ),
      .bus_req_o ( bus_req  ) );

   ahb_decoder #(
      .SRAM_BASE    ( SRAM_BASE  ),
      .SRAM_MASK    ( SRAM_MASK  ),
      .TMR_BASE     ( TMR_BASE   ),
      .TMR_MASK     ( TMR_MASK   ) )
   decoder (
      .hclk_i       ( hclk_i     ),
      .rst_n_i      ( rst_n_i    ),
      .bus_req_i    ( bus_req    ),
      .sram_rdata_i ( sram_rdata ),
      .sram_ready_i ( sram_ready ),
      .tmr_rdata_i  ( tmr_rdata  ),
      .tmr_ready_i  ( tmr_ready  ),
      .hsel_o       ( hsel       ),
      .bus_rsp_o    ( bus_rsp    ) );

   ahb_sram #(
      .SRAM_DEPTH  ( SRAM_DEPTH              ) )
   ram (
      .hclk_i      ( hclk_i                  ),
      .rst_n_i     ( rst_n_i                 ),
      .hsel_i      ( hsel[soc_pkg::SEL_SRAM] ),
      .req_i       ( bus_req                 ),
      .hready_i    ( bus_rsp.hready          ),
      .hrdata_o    ( sram_rdata              ),
      .hreadyout_o ( sram_ready              ) );

   timer_regs timer0_regs (
      .hclk_i      ( hclk_i                 ),
      .rst_n_i     ( rst_n_i                ),
      .hsel_i      ( hsel[soc_pkg::SEL_TMR] ),
      .req_i       ( bus_req                ),
      .hready_i    ( bus_rsp.hready         ),
      .match_i     ( tmr_match              ),
      .count_i     ( tmr_count              ),
      .hrdata_o    ( tmr_rdata              ),
      .hreadyout_o ( tmr_ready              ),
      .enable_o    ( tmr_enable             ),
      .cmp_o       ( tmr_cmp                ),
      .irq_o       ( irq_o                  ) );

   timer_counter timer0_cnt (
      .hclk_i   ( hclk_i     ),
      .rst_n_i  ( rst_n_i    ),
      .enable_i ( tmr_enable ),
      .cmp_i    ( tmr_cmp    ),
      .count_o  ( tmr_count  ),
      .match_o  ( tmr_match  ) );

endmodule

//--- verif/tb_fabric.sv
/* testbench for the two-master fabric, both master ports driven directly
   during sram traffic each master keeps to its own half of the memory,
   so the model stays exact when master 1 gets its response late */
`timescale 1ns/1ns

module tb_fabric;

   localparam soc_pkg::addr_t SRAM_BASE  = 32'h2000_0000;
   localparam soc_pkg::addr_t SRAM_MASK  = 32'hE000_0000;
   localparam soc_pkg::addr_t TMR_BASE   = 32'h4000_0400;
   localparam soc_pkg::addr_t TMR_MASK   = 32'hFFFF_FFC0;
   localparam int             SRAM_DEPTH = 512;
   localparam int             N_XFER     = 150;      // per master
   localparam int             N_UNMAP    = 20;
   localparam int             MAX_CYCLES = 20000;

   logic              hclk = 1'b0;
   logic              rst_n;
   soc_pkg::ahb_req_t m0_req;
   soc_pkg::ahb_req_t m1_req;
   soc_pkg::ahb_rsp_t m0_rsp;
   soc_pkg::ahb_rsp_t m1_rsp;
   logic              irq;

   integer            seed = 13;
   int                errors = 0;
   int                xfers = 0;
   int                cycle_cnt = 0;
   soc_pkg::data_t    sram_model [SRAM_DEPTH];
   logic [1:0]        tmr_ctrl;                  // {irq enable, count enable}
   soc_pkg::data_t    tmr_cmp;

   ahb_fabric_top #(
      .SRAM_BASE  ( SRAM_BASE  ),
      .SRAM_MASK  ( SRAM_MASK  ),
      .TMR_BASE   ( TMR_BASE   ),
      .TMR_MASK   ( TMR_MASK   ),
      .SRAM_DEPTH ( SRAM_DEPTH ) )
   UUT (
      .hclk_i     ( hclk       ),
      .rst_n_i    ( rst_n      ),
      .m0_req_i   ( m0_req     ),
      .m1_req_i   ( m1_req     ),
      .m0_rsp_o   ( m0_rsp     ),
      .m1_rsp_o   ( m1_rsp     ),
      .irq_o      ( irq        ) );

   always #20 hclk = ~hclk;

   always @(posedge hclk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run did not end within %0d cycles, errors: %0d", cycle_cnt, errors);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // bus helpers

   task automatic drive_req(input int m, input soc_pkg::ahb_req_t req);
      if (m == 0) begin
         m0_req = req;
      end else begin
         m1_req = req;
      end
   endtask

   function automatic soc_pkg::ahb_rsp_t get_rsp(input int m);
      return (m == 0) ? m0_rsp : m1_rsp;
   endfunction

   // bit 10 picks the master's half, alias bits above are ignored by the region
   function automatic soc_pkg::addr_t sram_addr(input int m);
      soc_pkg::data_t r;
      r = $random(seed);
      return SRAM_BASE | (r & 32'h1FFF_F800) | (m << 10) | {24'd0, r[5:0], 2'b00};
   endfunction

   // one transfer, address phase then data phase, nothing overlapped
   task automatic single_xfer(input int m, input soc_pkg::addr_t addr, input logic wr,
                              input soc_pkg::data_t wdata, output soc_pkg::data_t rdata,
                              output logic resp, output int waits, output logic err_waits);
      soc_pkg::ahb_req_t req;
      soc_pkg::ahb_rsp_t rsp;
      req        = '0;
      req.htrans = soc_pkg::NONSEQ;
      req.haddr  = addr;
      req.hwrite = wr;
      waits      = 0;
      err_waits  = 1'b1;                          // hresp high in every wait cycle
      @(posedge hclk);
      #2;
      drive_req(m, req);
      @(negedge hclk);
      rsp = get_rsp(m);
      while (!rsp.hready) begin
         @(negedge hclk);
         rsp = get_rsp(m);
      end
      @(posedge hclk);
      #2;
      req.htrans = soc_pkg::IDLE;
      req.hwdata = wdata;
      drive_req(m, req);
      @(negedge hclk);
      rsp = get_rsp(m);
      while (!rsp.hready) begin
         waits++;
         if (!rsp.hresp) begin
            err_waits = 1'b0;
         end
         @(negedge hclk);
         rsp = get_rsp(m);
      end
      rdata = rsp.hrdata;
      resp  = rsp.hresp;
      xfers++;
   endtask

   task automatic reg_access(input logic wr, input logic [3:0] off,
                             input soc_pkg::data_t wdata, output soc_pkg::data_t rdata);
      logic resp;
      int   waits;
      logic err_waits;
      single_xfer(0, TMR_BASE | {28'd0, off}, wr, wdata, rdata, resp, waits, err_waits);
      if (resp || waits != 0) begin
         $display("timer access to offset %h did not finish cleanly in one cycle", off);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // sram traffic, both masters pipelined

   task automatic sram_traffic(output int contention);
      logic              ap_vld  [2];
      soc_pkg::addr_t    ap_addr [2];
      logic              ap_wr   [2];
      soc_pkg::data_t    ap_data [2];
      logic              dp_vld  [2];
      soc_pkg::addr_t    dp_addr [2];
      logic              dp_wr   [2];
      soc_pkg::data_t    dp_data [2];
      int                issued  [2];
      soc_pkg::ahb_rsp_t rsp     [2];
      soc_pkg::ahb_req_t req;
      soc_pkg::data_t    r;
      logic [8:0]        idx;
      contention = 0;
      for (int m = 0; m < 2; m++) begin
         ap_vld[m]  = 1'b0;
         ap_addr[m] = '0;
         ap_wr[m]   = 1'b0;
         ap_data[m] = '0;
         dp_vld[m]  = 1'b0;
         dp_addr[m] = '0;
         dp_wr[m]   = 1'b0;
         dp_data[m] = '0;
         issued[m]  = 0;
      end
      while (issued[0] < N_XFER || issued[1] < N_XFER || ap_vld[0] || ap_vld[1]
             || dp_vld[0] || dp_vld[1]) begin
         @(posedge hclk);
         #2;
         for (int m = 0; m < 2; m++) begin
            req        = '0;
            req.htrans = ap_vld[m] ? soc_pkg::NONSEQ : soc_pkg::IDLE;
            req.haddr  = ap_addr[m];
            req.hwrite = ap_wr[m];
            req.hwdata = dp_data[m];              // held until the data phase ends
            drive_req(m, req);
         end
         @(negedge hclk);
         rsp[0] = m0_rsp;
         rsp[1] = m1_rsp;
         if (ap_vld[0] && ap_vld[1]) begin
            contention++;
            if (!rsp[0].hready || rsp[1].hready) begin
               $display("Fail m0/m1 hready under contention: expected 1/0, got %h/%h",
                        rsp[0].hready, rsp[1].hready);
               errors++;
            end
         end
         for (int m = 0; m < 2; m++) begin
            if (rsp[m].hready) begin
               if (dp_vld[m]) begin
                  idx = dp_addr[m][10:2];
                  if (rsp[m].hresp) begin
                     $display("sram transfer of master %0d at %h ended in an error",
                              m, dp_addr[m]);
                     errors++;
                  end
                  if (dp_wr[m]) begin
                     sram_model[idx] = dp_data[m];
                  end else if (rsp[m].hrdata !== sram_model[idx]) begin
                     $display("Fail m%0d_rsp_o.hrdata at %h: expected %h, got %h",
                              m, dp_addr[m], sram_model[idx], rsp[m].hrdata);
                     errors++;
                  end
                  xfers++;
               end
               dp_vld[m]  = ap_vld[m];
               dp_addr[m] = ap_addr[m];
               dp_wr[m]   = ap_wr[m];
               dp_data[m] = ap_data[m];
               r = $random(seed);
               // master 0 idles now and then, master 1 always wants the bus
               ap_vld[m] = (issued[m] < N_XFER) && (m == 1 || r[1:0] != 2'b00);
               if (ap_vld[m]) begin
                  ap_addr[m] = sram_addr(m);
                  ap_wr[m]   = r[4];
                  ap_data[m] = $random(seed);
                  issued[m]++;
               end
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // default slave

   task automatic unmapped_test();
      soc_pkg::addr_t addr;
      soc_pkg::data_t r;
      soc_pkg::data_t rdata;
      logic           resp;
      int             waits;
      logic           err_waits;
      logic [8:0]     idx;
      for (int i = 0; i < N_UNMAP; i++) begin
         addr = SRAM_BASE;
         while (((addr & SRAM_MASK) == SRAM_BASE) || ((addr & TMR_MASK) == TMR_BASE)) begin
            r    = $random(seed);
            addr = {r[31:2], 2'b00};
         end
         single_xfer(i % 2, addr, r[0], $random(seed), rdata, resp, waits, err_waits);
         if (waits != 1) begin
            $display("Fail m%0d_rsp_o.hready low cycles at %h: expected 1, got %h",
                     i % 2, addr, waits);
            errors++;
         end
         if (!resp || !err_waits) begin
            $display("Fail m%0d_rsp_o.hresp at %h: expected 1/1, got %h/%h",
                     i % 2, addr, err_waits, resp);
            errors++;
         end
         if (rdata !== 32'd0) begin
            $display("Fail m%0d_rsp_o.hrdata at %h: expected 0, got %h", i % 2, addr, rdata);
            errors++;
         end
         // the following mapped read must be clean
         addr = sram_addr(i % 2);
         idx  = addr[10:2];
         single_xfer(i % 2, addr, 1'b0, '0, rdata, resp, waits, err_waits);
         if (resp || waits != 0) begin
            $display("sram read after an unmapped access did not finish cleanly");
            errors++;
         end
         if (rdata !== sram_model[idx]) begin
            $display("Fail m%0d_rsp_o.hrdata at %h: expected %h, got %h",
                     i % 2, addr, sram_model[idx], rdata);
            errors++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // timer

   task automatic count_hold_check();
      soc_pkg::data_t first;
      soc_pkg::data_t second;
      reg_access(1'b0, soc_pkg::TMR_COUNT, '0, first);
      reg_access(1'b0, soc_pkg::TMR_COUNT, '0, second);
      if (second !== first) begin
         $display("Fail TMR_COUNT while stopped: expected %h, got %h", first, second);
         errors++;
      end
   endtask

   task automatic ctrl_cmp_check();
      soc_pkg::data_t rdata;
      reg_access(1'b0, soc_pkg::TMR_CTRL, '0, rdata);
      if (rdata !== {30'd0, tmr_ctrl}) begin
         $display("Fail TMR_CTRL: expected %h, got %h", {30'd0, tmr_ctrl}, rdata);
         errors++;
      end
      reg_access(1'b0, soc_pkg::TMR_CMP, '0, rdata);
      if (rdata !== tmr_cmp) begin
         $display("Fail TMR_CMP: expected %h, got %h", tmr_cmp, rdata);
         errors++;
      end
   endtask

   task automatic timer_test();
      soc_pkg::data_t rdata;
      soc_pkg::data_t r;
      int             n;
      int             k;
      // counter never enabled so far, count sits at zero
      r        = $random(seed);
      tmr_ctrl = {r[1], 1'b0};
      tmr_cmp  = $random(seed);
      reg_access(1'b1, soc_pkg::TMR_CTRL, {30'd0, tmr_ctrl}, rdata);
      reg_access(1'b1, soc_pkg::TMR_CMP, tmr_cmp, rdata);
      ctrl_cmp_check();
      count_hold_check();
      r        = $random(seed);
      n        = 4 + int'(r % 32'd37);             // 4 to 40
      tmr_cmp  = n;
      tmr_ctrl = 2'b11;
      reg_access(1'b1, soc_pkg::TMR_CMP, tmr_cmp, rdata);
      reg_access(1'b1, soc_pkg::TMR_CTRL, {30'd0, tmr_ctrl}, rdata);
      k = 0;
      while (!irq && k <= n + 8) begin
         @(negedge hclk);
         k++;
      end
      if (!irq) begin
         $display("irq_o never rose with compare %0d and the timer enabled", n);
         errors++;
      end else if (k != n + 2) begin
         $display("Fail irq_o rise cycle: expected %h, got %h", n + 2, k);
         errors++;
      end
      // stop the count, then clear pending
      tmr_ctrl = 2'b10;
      reg_access(1'b1, soc_pkg::TMR_CTRL, {30'd0, tmr_ctrl}, rdata);
      count_hold_check();
      reg_access(1'b1, soc_pkg::TMR_STAT, 32'd1, rdata);
      if (!irq) begin
         $display("irq_o dropped before the pending bit was cleared");
         errors++;
      end
      @(negedge hclk);
      if (irq) begin
         $display("Fail irq_o after clear: expected 0, got %h", irq);
         errors++;
      end
      // count again with irq enable clear
      tmr_ctrl = 2'b01;
      reg_access(1'b1, soc_pkg::TMR_CTRL, {30'd0, tmr_ctrl}, rdata);
      for (int i = 0; i < 2 * n + 4; i++) begin
         @(negedge hclk);
         if (irq) begin
            $display("Fail irq_o with irq enable clear: expected 0, got %h", irq);
            errors++;
         end
      end
      reg_access(1'b0, soc_pkg::TMR_STAT, '0, rdata);
      if (rdata !== 32'd1) begin
         $display("Fail TMR_STAT: expected 00000001, got %h", rdata);
         errors++;
      end
      tmr_ctrl = 2'b00;
      reg_access(1'b1, soc_pkg::TMR_CTRL, {30'd0, tmr_ctrl}, rdata);
      count_hold_check();
      ctrl_cmp_check();
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      int contention;
      m0_req   = '0;
      m1_req   = '0;
      rst_n    = 1'b0;
      tmr_ctrl = '0;
      tmr_cmp  = '0;
      for (int i = 0; i < SRAM_DEPTH; i++) begin
         sram_model[i] = '0;                      // unwritten words read as zero
      end
      repeat (10) @(posedge hclk);
      #2;
      rst_n = 1'b1;
      @(negedge hclk);
      if (!m0_rsp.hready || !m1_rsp.hready) begin
         $display("Fail m0/m1 hready after reset: expected 1/1, got %h/%h",
                  m0_rsp.hready, m1_rsp.hready);
         errors++;
      end
      if (m0_rsp.hresp || m1_rsp.hresp) begin
         $display("Fail m0/m1 hresp after reset: expected 0/0, got %h/%h",
                  m0_rsp.hresp, m1_rsp.hresp);
         errors++;
      end
      if (irq) begin
         $display("Fail irq_o after reset: expected 0, got %h", irq);
         errors++;
      end
      sram_traffic(contention);
      if (contention == 0) begin
         $display("the two masters never competed for the bus in the same cycle");
         errors++;
      end
      unmapped_test();
      timer_test();
      repeat (2) @(posedge hclk);
      $display("errors: %0d, transfers: %0d, contention cycles: %0d",
               errors, xfers, contention);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- compile.f
hw/soc_pkg.sv
hw/timer_counter.sv
hw/timer_regs.sv
hw/ahb_sram.sv
hw/ahb_decoder.sv
hw/ahb_arbiter.sv
hw/ahb_fabric_top.sv
verif/tb_fabric.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fabric testbench with Verilator
# exits 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_fabric -f compile.f -o tb_fabric
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_fabric)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^Simulation finished: PASS$"; then
   exit 0
fi
exit 1
